// ==== hdl/dmm_pkg.sv ====
package dmm_pkg;

  //////////////////////////////////////////////////////////////////////
  // field widths

  localparam int REG_DATA_W  = 24;                     // register payload
  localparam int ADDR_W      = 8;                      // address byte
  localparam int FRAME_W     = ADDR_W + REG_DATA_W;    // one spi frame, 32
  localparam int MODE_W      = 3;                      // low bits of REG_CR
  localparam int SEQ_N_W     = 3;                      // sequence length field
  localparam int SEQ_ENTRY_W = 6;                      // {pc_sw[1:0], azmux[3:0]}
  localparam int SEQ_IDX_W   = 2;                      // sample index
  localparam int NUM_ENTRIES = 4;                      // seq0 .. seq3

  // low byte of the status word, lets the host check the link
  localparam logic [7:0] STATUS_MAGIC = 8'b1010_1010;

  //////////////////////////////////////////////////////////////////////
  // encodings

  // output pin modes, anything else drives zeros
  typedef enum logic [MODE_W-1:0] {
    MODE_DIRECT   = 3'd0,   // REG_DIRECT on the pins
    MODE_SEQ_MOCK = 3'd6    // sequencer with mocked adc
  } mode_t;

  // chip-select vector on the shared bus
  typedef enum logic [2:0] {
    CS_DEASSERT   = 3'd0,
    CS_FPGA0      = 3'd1,   // this register set
    CS_4094       = 3'd2,
    CS_INVERT_DAC = 3'd3,
    CS_MDAC1      = 3'd4
  } spi_cs_t;

  typedef enum logic [ADDR_W-1:0] {
    REG_CR           = 8'd1,
    REG_DIRECT       = 8'd2,
    REG_4094_OE      = 8'd3,
    REG_STATUS       = 8'd4,    // read only
    REG_SA_PRECHARGE = 8'd5,
    REG_SA_SEQ_N     = 8'd6,
    REG_SA_SEQ0      = 8'd7,
    REG_SA_SEQ1      = 8'd8,
    REG_SA_SEQ2      = 8'd9,
    REG_SA_SEQ3      = 8'd10,
    REG_ADC_APERTURE = 8'd11
  } reg_addr_t;

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    PRECHARGE = 2'd1,
    MEASURE   = 2'd2
  } sa_state_t;

endpackage

// ==== hdl/spi_register_set.sv ====
`timescale 1ns/1ps

module spi_register_set #(
  parameter int COUNT_W = 24
) (
  input  logic                                 CLK,
  input  logic                                 rst_n_i,
  input  logic                                 spi_sel_i,          // decoded, active hi
  input  logic                                 spi_sck_i,
  input  logic                                 spi_sdi_i,
  input  logic [3:0]                           hw_flags_i,
  input  logic [dmm_pkg::SEQ_IDX_W-1:0]        sample_idx_last_i,
  input  logic                                 first_last_i,
  output logic                                 spi_sdo_o,
  output logic [dmm_pkg::MODE_W-1:0]           reg_cr_o,
  output logic [dmm_pkg::REG_DATA_W-1:0]       reg_direct_o,
  output logic                                 reg_4094_oe_o,
  output logic [COUNT_W-1:0]                   precharge_o,
  output logic [dmm_pkg::SEQ_N_W-1:0]          seq_n_o,
  output logic [dmm_pkg::NUM_ENTRIES-1:0][dmm_pkg::SEQ_ENTRY_W-1:0] seq_entries_o,
  output logic [COUNT_W-1:0]                   aperture_o
);
  import dmm_pkg::*;

  localparam int CNT_W = $clog2(FRAME_W) + 1;   // must hold 32 and beyond

  logic [2:0]            sck_q;        // two sync flops plus edge history
  logic [2:0]            sel_q;
  logic [1:0]            sdi_q;        // aligned with sck_q[1]
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  sel_rise;
  logic                  sel_fall;
  logic [FRAME_W-1:0]    shift_q;
  logic [CNT_W-1:0]      bit_cnt_q;
  logic                  sdo_q;
  logic [ADDR_W-1:0]     addr_next;
  logic [REG_DATA_W-1:0] rd_data;
  logic [REG_DATA_W-1:0] status_word;
  logic [ADDR_W-1:0]     wr_addr;
  logic [REG_DATA_W-1:0] wr_data;
  logic                  commit;

  //////////////////////////////////////////////////////////////////////
  // line synchronizers, everything runs on CLK

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      sck_q <= '0;
      sel_q <= '0;
      sdi_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], spi_sck_i};
      sel_q <= {sel_q[1:0], spi_sel_i};
      sdi_q <= {sdi_q[0], spi_sdi_i};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign sel_rise = sel_q[1] & ~sel_q[2];   // frame start
  assign sel_fall = ~sel_q[1] & sel_q[2];   // frame end

  //////////////////////////////////////////////////////////////////////
  // frame shifter
  // address shifts in first; on its last bit the read value is loaded
  // above it, so data shifts in at the bottom while the read value
  // leaves at the top. after 32 bits the frame is {addr, data} again

  assign addr_next = {shift_q[ADDR_W-2:0], sdi_q[1]};   // address incl. current bit

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      shift_q   <= '0;
      bit_cnt_q <= '0;
      sdo_q     <= 1'b0;
    end else if (sel_rise) begin
      shift_q   <= '0;                                   // sdo low during address
      bit_cnt_q <= '0;
    end else if (sel_q[1] && sck_rise) begin
      if (bit_cnt_q == CNT_W'(ADDR_W - 1)) begin
        shift_q <= {rd_data, addr_next};                 // load read value
      end else begin
        shift_q <= {shift_q[FRAME_W-2:0], sdi_q[1]};
      end
      if (bit_cnt_q != '1) bit_cnt_q <= bit_cnt_q + 1'b1; // saturate, flags overlong frames
    end else if (sel_q[1] && sck_fall) begin
      sdo_q <= shift_q[FRAME_W-1];                       // mode 0, change on falling
    end
  end

  assign spi_sdo_o = sdo_q;

  //////////////////////////////////////////////////////////////////////
  // read side

  // 6 pad + 3 seq_n + 1 + 2 idx + 4 flags + 8 magic
  assign status_word = {{(REG_DATA_W - 18){1'b0}}, seq_n_o, first_last_i,
                        sample_idx_last_i, hw_flags_i, STATUS_MAGIC};

  always_comb begin
    case (reg_addr_t'(addr_next))
      REG_CR:           rd_data = REG_DATA_W'(reg_cr_o);
      REG_DIRECT:       rd_data = reg_direct_o;
      REG_4094_OE:      rd_data = REG_DATA_W'(reg_4094_oe_o);
      REG_STATUS:       rd_data = status_word;
      REG_SA_PRECHARGE: rd_data = REG_DATA_W'(precharge_o);
      REG_SA_SEQ_N:     rd_data = REG_DATA_W'(seq_n_o);
      REG_SA_SEQ0:      rd_data = REG_DATA_W'(seq_entries_o[0]);
      REG_SA_SEQ1:      rd_data = REG_DATA_W'(seq_entries_o[1]);
      REG_SA_SEQ2:      rd_data = REG_DATA_W'(seq_entries_o[2]);
      REG_SA_SEQ3:      rd_data = REG_DATA_W'(seq_entries_o[3]);
      REG_ADC_APERTURE: rd_data = REG_DATA_W'(aperture_o);
      default:          rd_data = '0;                    // unknown reads zero
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // write commit at frame end, only on exactly 32 bits

  assign wr_addr = shift_q[FRAME_W-1 -: ADDR_W];
  assign wr_data = shift_q[REG_DATA_W-1:0];
  assign commit  = sel_fall && (bit_cnt_q == CNT_W'(FRAME_W));

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      reg_cr_o      <= '0;
      reg_direct_o  <= '0;
      reg_4094_oe_o <= 1'b0;     // 4094 outputs start disabled
      precharge_o   <= '0;
      seq_n_o       <= '0;
      seq_entries_o <= '0;
      aperture_o    <= '0;
    end else if (commit) begin
      case (reg_addr_t'(wr_addr))
        REG_CR:           reg_cr_o         <= wr_data[MODE_W-1:0];
        REG_DIRECT:       reg_direct_o     <= wr_data;
        REG_4094_OE:      reg_4094_oe_o    <= wr_data[0];
        REG_SA_PRECHARGE: precharge_o      <= COUNT_W'(wr_data);
        REG_SA_SEQ_N:     seq_n_o          <= wr_data[SEQ_N_W-1:0];
        REG_SA_SEQ0:      seq_entries_o[0] <= wr_data[SEQ_ENTRY_W-1:0];
        REG_SA_SEQ1:      seq_entries_o[1] <= wr_data[SEQ_ENTRY_W-1:0];
        REG_SA_SEQ2:      seq_entries_o[2] <= wr_data[SEQ_ENTRY_W-1:0];
        REG_SA_SEQ3:      seq_entries_o[3] <= wr_data[SEQ_ENTRY_W-1:0];
        REG_ADC_APERTURE: aperture_o       <= COUNT_W'(wr_data);
        default: ;                                       // status and unknown ignored
      endcase
    end
  end

endmodule

// ==== hdl/sequence_acquisition.sv ====
`timescale 1ns/1ps

module sequence_acquisition #(
  parameter int COUNT_W = 24
) (
  input  logic                                 CLK,
  input  logic                                 rst_n_i,
  input  logic                                 sa_trig_i,       // async, level
  input  logic                                 measure_valid_i, // end of aperture
  input  logic [COUNT_W-1:0]                   precharge_i,
  input  logic [dmm_pkg::SEQ_N_W-1:0]          seq_n_i,
  input  logic [dmm_pkg::NUM_ENTRIES-1:0][dmm_pkg::SEQ_ENTRY_W-1:0] seq_entries_i,
  output logic [3:0]                           azmux_o,
  output logic [1:0]                           pc_sw_o,
  output logic                                 adc_reset_n_o,
  output logic [dmm_pkg::SEQ_IDX_W-1:0]        sample_idx_o,
  output logic [dmm_pkg::SEQ_IDX_W-1:0]        sample_idx_last_o,
  output logic                                 first_last_o
);
  import dmm_pkg::*;

  logic [1:0]             trig_q;       // trigger synchronizer
  sa_state_t              state_q;
  logic [COUNT_W-1:0]     pc_cnt_q;     // cycles spent in precharge
  logic [SEQ_IDX_W-1:0]   idx_q;
  logic [SEQ_N_W-1:0]     seq_n_eff;
  logic                   idx_wrap;
  logic                   pc_done;
  logic [SEQ_ENTRY_W-1:0] entry;
  logic                   sample_done;

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      trig_q <= '0;
    end else begin
      trig_q <= {trig_q[0], sa_trig_i};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequence bookkeeping

  assign seq_n_eff   = (seq_n_i == '0) ? SEQ_N_W'(1) : seq_n_i;         // 0 runs as 1
  assign idx_wrap    = (SEQ_N_W'(idx_q) + SEQ_N_W'(1)) >= seq_n_eff;    // above 4 wraps at 4
  assign pc_done     = (pc_cnt_q + COUNT_W'(1)) >= precharge_i;         // 0 runs as 1 cycle
  assign entry       = seq_entries_i[idx_q];
  assign sample_done = (state_q == MEASURE) && measure_valid_i;

  //////////////////////////////////////////////////////////////////////
  // fsm, held idle while the trigger is low

  always_ff @(posedge CLK) begin
    if (!rst_n_i || !trig_q[1]) begin
      state_q  <= IDLE;
      pc_cnt_q <= '0;
      idx_q    <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          state_q  <= PRECHARGE;
          pc_cnt_q <= '0;
        end
        PRECHARGE: begin
          if (pc_done) begin
            state_q <= MEASURE;                  // release adc reset
          end else begin
            pc_cnt_q <= pc_cnt_q + 1'b1;
          end
        end
        MEASURE: begin
          if (measure_valid_i) begin
            state_q  <= PRECHARGE;               // next sample, adc back in reset
            pc_cnt_q <= '0;
            idx_q    <= idx_wrap ? '0 : idx_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // last completed sample, kept across trigger low for the host
  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      sample_idx_last_o <= '0;
      first_last_o      <= 1'b0;
    end else if (sample_done) begin
      sample_idx_last_o <= idx_q;
      first_last_o      <= (idx_q == '0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs, decoded from registered state

  assign azmux_o       = (state_q != IDLE) ? entry[3:0] : 4'b0;   // entry low nibble
  assign pc_sw_o       = (state_q != IDLE) ? entry[5:4] : 2'b0;   // entry top bits
  assign adc_reset_n_o = (state_q == MEASURE);                     // aperture runs here
  assign sample_idx_o  = idx_q;

endmodule

// ==== hdl/adc_mock.sv ====
`timescale 1ns/1ps

// stands in for the modulating adc, just times the aperture
module adc_mock #(
  parameter int COUNT_W = 24
) (
  input  logic               CLK,
  input  logic               adc_reset_n_i,   // from the sequencer, sync active lo
  input  logic [COUNT_W-1:0] aperture_i,      // clk cycles per sample
  output logic               measure_valid_o
);

  logic [COUNT_W-1:0] cnt_q;     // cycles since reset release
  logic               done_q;    // sample finished, wait for next reset
  logic               hit;

  // 0 treated as 1
  assign hit = (cnt_q + COUNT_W'(1)) >= aperture_i;

  always_ff @(posedge CLK) begin
    if (!adc_reset_n_i) begin
      cnt_q           <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;               // single cycle pulse
      if (!done_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (hit) begin
          measure_valid_o <= 1'b1;           // aperture cycles after release
          done_q          <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/dmm_top.sv ====
`timescale 1ns/1ps

module dmm_top #(
  parameter int COUNT_W = 24       // precharge and aperture counters
) (
  input  logic             CLK,
  input  logic             rst_n_i,
  input  logic             spi_sck_i,
  input  logic             spi_sdi_i,
  input  dmm_pkg::spi_cs_t spi_cs_vec_i,
  input  logic             spi_glb_miso_i,
  input  logic [3:0]       hw_flags_i,
  input  logic             sa_trig_i,
  output logic             spi_sdo_o,
  output logic             spi_glb_clk_o,
  output logic             spi_glb_mosi_o,
  output logic             spi_4094_strobe_o,
  output logic             spi_4094_oe_o,
  output logic             spi_iso_cs_o,
  output logic             spi_invert_dac_data_o,
  output logic             spi_invert_dac_clk_o,
  output logic             spi_invert_dac_ss_o,
  output logic [3:0]       leds_o,
  output logic [7:0]       monitor_o,
  output logic [1:0]       pc_sw_o,
  output logic [3:0]       azmux_o,
  output logic [1:0]       adc_refmux_o,
  output logic             spi_interrupt_o
);
  import dmm_pkg::*;

  logic                                     fpga_sel;
  logic                                     regs_sdo;
  logic [MODE_W-1:0]                        reg_cr;
  logic [REG_DATA_W-1:0]                    reg_direct;
  logic [COUNT_W-1:0]                       precharge;
  logic [SEQ_N_W-1:0]                       seq_n;
  logic [NUM_ENTRIES-1:0][SEQ_ENTRY_W-1:0]  seq_entries;
  logic [COUNT_W-1:0]                       aperture;
  logic [3:0]                               sa_azmux;
  logic [1:0]                               sa_pc_sw;
  logic                                     adc_reset_n;
  logic                                     measure_valid;
  logic [SEQ_IDX_W-1:0]                     sa_idx;
  logic [SEQ_IDX_W-1:0]                     sa_idx_last;
  logic                                     sa_first_last;

  //////////////////////////////////////////////////////////////////////
  // spi cs decode and bus pass-through

  assign fpga_sel = (spi_cs_vec_i == CS_FPGA0);

  assign spi_glb_clk_o  = fpga_sel ? 1'b1 : spi_sck_i;   // park hi while we own the bus
  assign spi_glb_mosi_o = fpga_sel ? 1'b1 : spi_sdi_i;
  assign spi_invert_dac_data_o = spi_glb_mosi_o;
  assign spi_invert_dac_clk_o  = spi_glb_clk_o;

  assign spi_4094_strobe_o   = (spi_cs_vec_i == CS_4094);         // active hi
  assign spi_invert_dac_ss_o = (spi_cs_vec_i != CS_INVERT_DAC);   // active lo
  assign spi_iso_cs_o        = (spi_cs_vec_i != CS_MDAC1);        // active lo
  assign spi_sdo_o           = fpga_sel ? regs_sdo : spi_glb_miso_i;  // devices read back

  spi_register_set #(.COUNT_W(COUNT_W)) u_spi_register_set (
    .CLK              (CLK),
    .rst_n_i          (rst_n_i),
    .spi_sel_i        (fpga_sel),
    .spi_sck_i        (spi_sck_i),
    .spi_sdi_i        (spi_sdi_i),
    .hw_flags_i       (hw_flags_i),
    .sample_idx_last_i(sa_idx_last),
    .first_last_i     (sa_first_last),
    .spi_sdo_o        (regs_sdo),
    .reg_cr_o         (reg_cr),
    .reg_direct_o     (reg_direct),
    .reg_4094_oe_o    (spi_4094_oe_o),
    .precharge_o      (precharge),
    .seq_n_o          (seq_n),
    .seq_entries_o    (seq_entries),
    .aperture_o       (aperture)
  );

  sequence_acquisition #(.COUNT_W(COUNT_W)) u_sequence_acquisition (
    .CLK              (CLK),
    .rst_n_i          (rst_n_i),
    .sa_trig_i        (sa_trig_i),
    .measure_valid_i  (measure_valid),
    .precharge_i      (precharge),
    .seq_n_i          (seq_n),
    .seq_entries_i    (seq_entries),
    .azmux_o          (sa_azmux),
    .pc_sw_o          (sa_pc_sw),
    .adc_reset_n_o    (adc_reset_n),
    .sample_idx_o     (sa_idx),
    .sample_idx_last_o(sa_idx_last),
    .first_last_o     (sa_first_last)
  );

  adc_mock #(.COUNT_W(COUNT_W)) u_adc_mock (
    .CLK            (CLK),
    .adc_reset_n_i  (adc_reset_n),
    .aperture_i     (aperture),
    .measure_valid_o(measure_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // mode output mux

  always_comb begin
    leds_o          = '0;     // unused modes drive zeros
    monitor_o       = '0;
    pc_sw_o         = '0;
    azmux_o         = '0;
    adc_refmux_o    = '0;
    spi_interrupt_o = 1'b0;
    case (mode_t'(reg_cr))
      MODE_DIRECT: begin
        leds_o          = reg_direct[3:0];
        monitor_o       = reg_direct[11:4];
        pc_sw_o         = reg_direct[13:12];
        azmux_o         = reg_direct[17:14];
        adc_refmux_o    = reg_direct[19:18];
        spi_interrupt_o = reg_direct[20];
      end
      MODE_SEQ_MOCK: begin
        leds_o    = 4'b0001 << sa_idx;                          // one-hot index
        monitor_o = {4'b0, sa_idx, adc_reset_n, measure_valid};  // scope view
        azmux_o   = sa_azmux;
        pc_sw_o   = sa_pc_sw;
      end
      default: ;
    endcase
  end

endmodule

// ==== verification/dmm_top_assertions.sv ====
`timescale 1ns/1ps

module dmm_top_assertions (
  input logic                          CLK,
  input logic                          rst_n_i,
  input dmm_pkg::sa_state_t            state_i,
  input logic                          adc_reset_n_i,
  input logic                          measure_valid_i,
  input logic [dmm_pkg::SEQ_IDX_W-1:0] idx_i,
  input logic [dmm_pkg::SEQ_N_W-1:0]   seq_n_i
);
  import dmm_pkg::*;

  logic [SEQ_N_W-1:0] seq_n_eff;   // 0 runs as a single entry

  assign seq_n_eff = (seq_n_i == '0) ? SEQ_N_W'(1) : seq_n_i;

  // adc held in reset until the precharge has run out
  precharge_holds_reset: assert property (
    @(posedge CLK) disable iff (!rst_n_i)
    $rose(adc_reset_n_i) |-> ($past(state_i) == PRECHARGE)
  ) else $error("adc reset released without a preceding precharge");

  // finished sample puts the adc straight back into reset
  sample_end_resets_adc: assert property (
    @(posedge CLK) disable iff (!rst_n_i)
    ((state_i == MEASURE) && measure_valid_i) |=> !adc_reset_n_i
  ) else $error("adc reset not reasserted after measure_valid");

  valid_only_in_measure: assert property (
    @(posedge CLK) disable iff (!rst_n_i)
    measure_valid_i |-> (state_i == MEASURE)
  ) else $error("measure_valid seen outside the measure state");

  index_below_seq_n: assert property (
    @(posedge CLK) disable iff (!rst_n_i)
    SEQ_N_W'(idx_i) < seq_n_eff
  ) else $error("sample index reached seq_n");

endmodule

bind sequence_acquisition dmm_top_assertions u_dmm_top_assertions (
  .CLK            (CLK),
  .rst_n_i        (rst_n_i),
  .state_i        (state_q),
  .adc_reset_n_i  (adc_reset_n_o),
  .measure_valid_i(measure_valid_i),
  .idx_i          (idx_q),
  .seq_n_i        (seq_n_i)
);

// ==== verification/dmm_top_tb.sv ====
`timescale 1ns/1ps

module dmm_top_tb;
  import dmm_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int COUNT_W      = 24;
  localparam int SPI_HALF     = 5;                           // clk cycles per sck half
  localparam int FRAME_CYCLES = 9 + 64 * SPI_HALF + SPI_HALF;
  localparam int NUM_FRAMES   = 70;                          // all spi frames below
  localparam int PULSE_LIMIT  = 100;                         // one sample, worst case 28
  localparam int SEQ_CYCLES   = 3 * 9 * 30;                  // rounds x pulses x sample
  localparam int WORST_CYCLES = 10 + NUM_FRAMES * FRAME_CYCLES + SEQ_CYCLES + 100;

  logic        CLK;
  logic        rst_n_i;
  logic        spi_sck_i;
  logic        spi_sdi_i;
  spi_cs_t     spi_cs_vec_i;
  logic        spi_glb_miso_i;
  logic [3:0]  hw_flags_i;
  logic        sa_trig_i;
  logic        spi_sdo_o;
  logic        spi_glb_clk_o;
  logic        spi_glb_mosi_o;
  logic        spi_4094_strobe_o;
  logic        spi_4094_oe_o;
  logic        spi_iso_cs_o;
  logic        spi_invert_dac_data_o;
  logic        spi_invert_dac_clk_o;
  logic        spi_invert_dac_ss_o;
  logic [3:0]  leds_o;
  logic [7:0]  monitor_o;
  logic [1:0]  pc_sw_o;
  logic [3:0]  azmux_o;
  logic [1:0]  adc_refmux_o;
  logic        spi_interrupt_o;

  logic [31:0] lfsr_q;
  logic [23:0] model_regs [0:255];   // host view of the register bank
  logic [1:0]  exp_idx_last;         // last finished sample, model side
  logic        exp_first_last;
  int          cyc_cnt;              // negedges since round start
  int          rise_cyc;             // where adc reset last released
  logic        prev_rst;
  logic [5:0]  seq_entry [0:3];
  logic [7:0]  rb_addrs [0:6];

  dmm_top #(.COUNT_W(COUNT_W)) u_dmm_top (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1
    end else begin
      return s >> 1;
    end
  endfunction

  // one lfsr step per bit taken
  task automatic rand_bits(input int nbits, output logic [31:0] value);
    int b;
    value = '0;
    for (b = 0; b < nbits; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge CLK);
    #1;                                   // inputs move just after the edge
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
    end
  endtask

  // writable bits per address, 0 means read only or unknown
  function automatic logic [23:0] reg_mask(input logic [7:0] addr);
    case (addr)
      REG_CR, REG_SA_SEQ_N:                          return 24'h00_0007;
      REG_4094_OE:                                   return 24'h00_0001;
      REG_SA_SEQ0, REG_SA_SEQ1, REG_SA_SEQ2, REG_SA_SEQ3: return 24'h00_003f;
      REG_DIRECT, REG_SA_PRECHARGE, REG_ADC_APERTURE: return 24'hff_ffff;
      default:                                       return 24'h00_0000;
    endcase
  endfunction

  function automatic logic [23:0] status_model();
    return {6'b0, model_regs[REG_SA_SEQ_N][2:0], exp_first_last, exp_idx_last,
            hw_flags_i, STATUS_MAGIC};
  endfunction

  function automatic logic [23:0] expected_read(input logic [7:0] addr);
    if (addr == REG_STATUS) begin
      return status_model();
    end else begin
      return model_regs[addr];            // unknown stays zero
    end
  endfunction

  // one 32 bit frame, mode 0, msb first; checks the read, mirrors the write
  task automatic spi_xfer(input string name, input logic [7:0] addr, input logic [23:0] wdata);
    logic [31:0] frame;
    logic [23:0] expected;
    logic [23:0] rdata;
    logic [23:0] mask;
    int          i;
    frame    = {addr, wdata};
    expected = expected_read(addr);
    rdata    = '0;
    idle_cycles(1);
    spi_cs_vec_i = CS_FPGA0;
    idle_cycles(4);                       // let the select pass the synchronizer
    for (i = 31; i >= 0; i--) begin
      spi_sdi_i = frame[i];
      idle_cycles(SPI_HALF);
      if (i < 24) rdata = {rdata[22:0], spi_sdo_o};   // sample before rising sck
      spi_sck_i = 1'b1;
      idle_cycles(SPI_HALF);
      spi_sck_i = 1'b0;
    end
    idle_cycles(SPI_HALF);
    spi_cs_vec_i = CS_DEASSERT;           // frame end, commit
    idle_cycles(4);                       // write lands within 4 cycles
    check(name, 32'(expected), 32'(rdata));
    mask = reg_mask(addr);
    if (mask != '0) model_regs[addr] = wdata & mask;
  endtask

  // next measure_valid on the monitor port, tracks the reset release
  task automatic wait_valid();
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge CLK);
      cyc_cnt++;
      waited++;
      if (monitor_o[1] && !prev_rst) rise_cyc = cyc_cnt;
      prev_rst = monitor_o[1];
      if (monitor_o[0]) begin
        seen = 1'b1;
      end else if (waited > PULSE_LIMIT) begin
        abort_run("sequencer produced no measure_valid pulse in time");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // watchdog

  initial begin
    #(4 * WORST_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired, the run did not finish in time");
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] r;
    logic [23:0] dval;
    logic [1:0]  exp_idx;
    logic [3:0]  onehot;
    int          p_val;
    int          a_val;
    int          n_val;
    int          i;
    int          k;
    int          c;
    int          rnd;
    CLK            = 1'b0;
    rst_n_i        = 1'b0;
    spi_sck_i      = 1'b0;
    spi_sdi_i      = 1'b0;
    spi_cs_vec_i   = CS_DEASSERT;
    spi_glb_miso_i = 1'b0;
    hw_flags_i     = 4'h0;
    sa_trig_i      = 1'b0;
    lfsr_q         = 32'h508f;
    exp_idx_last   = 2'd0;
    exp_first_last = 1'b0;
    for (i = 0; i < 256; i++) model_regs[i] = '0;
    rb_addrs[0] = REG_SA_PRECHARGE;
    rb_addrs[1] = REG_SA_SEQ0;
    rb_addrs[2] = REG_SA_SEQ1;
    rb_addrs[3] = REG_SA_SEQ2;
    rb_addrs[4] = REG_SA_SEQ3;
    rb_addrs[5] = REG_ADC_APERTURE;
    rb_addrs[6] = REG_DIRECT;
    repeat (10) @(posedge CLK);
    #1;
    rst_n_i = 1'b1;

    // register read-back, each frame reads the old value
    for (k = 0; k < 3; k++) begin
      for (i = 0; i < 7; i++) begin
        rand_bits(24, r);
        spi_xfer("readback", rb_addrs[i], r[23:0]);
      end
    end
    for (k = 0; k < 2; k++) begin
      rand_bits(24, r);
      spi_xfer("status_write", REG_STATUS, r[23:0]);   // must not stick
      rand_bits(24, r);
      spi_xfer("unknown_addr", 8'h3c, r[23:0]);
    end

    // status word with flags and seq_n
    for (k = 0; k < 3; k++) begin
      rand_bits(4, r);
      idle_cycles(1);
      hw_flags_i = r[3:0];
      rand_bits(24, r);
      spi_xfer("seq_n_write", REG_SA_SEQ_N, r[23:0]);
      rand_bits(24, r);
      spi_xfer("status_word", REG_STATUS, r[23:0]);
    end

    // direct mode field map
    spi_xfer("direct_cr", REG_CR, 24'(MODE_DIRECT));
    for (k = 0; k < 4; k++) begin
      rand_bits(24, r);
      dval = r[23:0];
      spi_xfer("direct_reg", REG_DIRECT, dval);
      rand_bits(24, r);
      spi_xfer("direct_oe", REG_4094_OE, r[23:0]);
      @(negedge CLK);
      check("direct_leds", 32'(dval[3:0]), 32'(leds_o));
      check("direct_monitor", 32'(dval[11:4]), 32'(monitor_o));
      check("direct_pc_sw", 32'(dval[13:12]), 32'(pc_sw_o));
      check("direct_azmux", 32'(dval[17:14]), 32'(azmux_o));
      check("direct_refmux", 32'(dval[19:18]), 32'(adc_refmux_o));
      check("direct_irq", 32'(dval[20]), 32'(spi_interrupt_o));
      check("direct_4094_oe", 32'(r[0]), 32'(spi_4094_oe_o));
    end

    // cs decode and bus pass-through, combinational
    for (c = 0; c < 5; c++) begin
      for (k = 0; k < 4; k++) begin
        rand_bits(2, r);
        idle_cycles(1);
        spi_cs_vec_i = spi_cs_t'(c[2:0]);
        spi_sck_i    = r[0];
        spi_sdi_i    = r[1];
        @(negedge CLK);
        check("cs_glb_clk", 32'((c == 1) ? 1'b1 : r[0]), 32'(spi_glb_clk_o));
        check("cs_glb_mosi", 32'((c == 1) ? 1'b1 : r[1]), 32'(spi_glb_mosi_o));
        check("cs_dac_clk", 32'((c == 1) ? 1'b1 : r[0]), 32'(spi_invert_dac_clk_o));
        check("cs_dac_data", 32'((c == 1) ? 1'b1 : r[1]), 32'(spi_invert_dac_data_o));
        check("cs_4094_strobe", 32'(c == 2), 32'(spi_4094_strobe_o));
        check("cs_dac_ss", 32'(c != 3), 32'(spi_invert_dac_ss_o));
        check("cs_iso_cs", 32'(c != 4), 32'(spi_iso_cs_o));
      end
    end
    idle_cycles(1);
    spi_cs_vec_i = CS_DEASSERT;
    spi_sck_i    = 1'b0;
    spi_sdi_i    = 1'b0;

    // sequencer rounds with the mock adc
    for (rnd = 0; rnd < 3; rnd++) begin
      rand_bits(3, r);
      p_val = 2 + r[2:0];                 // 2..9
      rand_bits(4, r);
      a_val = 2 + r[3:0];                 // 2..17
      rand_bits(2, r);
      n_val = 1 + r[1:0];                 // 1..4
      rand_bits(6, r);
      for (i = 0; i < 4; i++) seq_entry[i] = r[5:0] + 6'(13 * i);  // odd step, distinct
      spi_xfer("seq_cfg", REG_SA_PRECHARGE, 24'(p_val));
      spi_xfer("seq_cfg", REG_ADC_APERTURE, 24'(a_val));
      spi_xfer("seq_cfg", REG_SA_SEQ_N, 24'(n_val));
      for (i = 0; i < 4; i++) begin
        spi_xfer("seq_cfg", 8'(int'(REG_SA_SEQ0) + i), 24'(seq_entry[i]));
      end
      spi_xfer("seq_cfg", REG_CR, 24'(MODE_SEQ_MOCK));
      idle_cycles(1);
      sa_trig_i = 1'b1;
      cyc_cnt   = 0;
      rise_cyc  = 0;
      prev_rst  = 1'b0;
      exp_idx   = 2'd0;
      for (k = 0; k < 2 * n_val + 1; k++) begin
        wait_valid();
        onehot          = '0;
        onehot[exp_idx] = 1'b1;           // led for the running entry
        check("seq_index", 32'(exp_idx), 32'(monitor_o[3:2]));
        check("seq_monitor_hi", 32'h0, 32'(monitor_o[7:4]));
        check("seq_leds", 32'(onehot), 32'(leds_o));
        check("seq_refmux", 32'h0, 32'(adc_refmux_o));
        check("seq_irq", 32'h0, 32'(spi_interrupt_o));
        check("seq_azmux", 32'(seq_entry[exp_idx][3:0]), 32'(azmux_o));
        check("seq_pc_sw", 32'(seq_entry[exp_idx][5:4]), 32'(pc_sw_o));
        check("seq_aperture", 32'(a_val), 32'(cyc_cnt - rise_cyc));
        exp_idx_last   = exp_idx;
        exp_first_last = (exp_idx == 2'd0);
        if (int'(exp_idx) + 1 >= n_val) begin
          exp_idx = 2'd0;                 // wrap after seq_n entries
        end else begin
          exp_idx = exp_idx + 2'd1;
        end
      end
      idle_cycles(1);
      sa_trig_i = 1'b0;                   // stops in precharge, before the next valid
      idle_cycles(8);
      rand_bits(24, r);
      spi_xfer("seq_status", REG_STATUS, r[23:0]);
    end

    // unused mode drives zeros
    rand_bits(21, r);
    spi_xfer("mode_unused", REG_CR, {r[20:0], 3'd3});
    spi_xfer("mode_unused", REG_DIRECT, 24'hff_ffff);
    @(negedge CLK);
    check("unused_leds", 32'h0, 32'(leds_o));
    check("unused_monitor", 32'h0, 32'(monitor_o));
    check("unused_pc_sw", 32'h0, 32'(pc_sw_o));
    check("unused_azmux", 32'h0, 32'(azmux_o));
    check("unused_refmux", 32'h0, 32'(adc_refmux_o));
    check("unused_irq", 32'h0, 32'(spi_interrupt_o));

    // seq mode, trigger low, sequencer parked
    spi_xfer("mode_idle", REG_CR, 24'(MODE_SEQ_MOCK));
    idle_cycles(4);
    @(negedge CLK);
    check("idle_azmux", 32'h0, 32'(azmux_o));
    check("idle_pc_sw", 32'h0, 32'(pc_sw_o));
    check("idle_monitor", 32'h0, 32'(monitor_o));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== dmm_top.f ====
hdl/dmm_pkg.sv
hdl/spi_register_set.sv
hdl/sequence_acquisition.sv
hdl/adc_mock.sv
hdl/dmm_top.sv
verification/dmm_top_assertions.sv
verification/dmm_top_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build dmm_top_tb with verilator and run it"
	@echo "  clean  remove obj_dir and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module dmm_top_tb \
		-f dmm_top.f -o Vdmm_top_tb
	-./obj_dir/Vdmm_top_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "simulation ended without passing"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
